// ==== Bender.yml ====
package:
  name: constant_source

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bus_pkg.sv
      - stream_pkg.sv
      - sb_write_decode.sv
      - constant_register_bank.sv
      - stream_emitter.sv
      - constant_source.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_constant_source.sv

// ==== bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // Width shared by address and data of the register bus
    localparam int sb_width = 32;

    // Byte address as seen on the bus
    typedef logic [sb_width-1:0] sb_addr_t;

    // One bus data word
    typedef logic [sb_width-1:0] sb_data_t;

    // Command decoded from the write offset
    typedef enum logic [1:0] {
        cmd_none     = 2'd0,
        cmd_emit     = 2'd1,
        cmd_set_high = 2'd2,
        cmd_set_dest = 2'd3
    } sb_cmd_e;

endpackage

`default_nettype wire

// ==== const_cfg.svh ====
`ifndef CONST_CFG_SVH
`define CONST_CFG_SVH

// Bus location of the constant source
`define CONST_BASE_ADDRESS 32'h43C0_0000

// Register byte offsets
`define CONST_OFS_LOW  32'h0000_0000
`define CONST_OFS_HIGH 32'h0000_0004
`define CONST_OFS_DEST 32'h0000_0008

// Emitted constant and routing tag
`define CONST_DATA_WIDTH 64
`define CONST_DEST_WIDTH 8

`endif

// ==== constant_register_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "const_cfg.svh"

module constant_register_bank import bus_pkg::*, stream_pkg::*; (
    input  wire              clock,
    input  wire              reset,
    input  wire sb_cmd_e     cmd,
    input  wire sb_data_t    cmd_data,
    input  wire              cmd_strobe,
    input  wire              emit_done,
    input  wire sb_addr_t    sb_address,
    output logic             cmd_done,
    output sb_data_t         sb_read_data,
    output logic             emit_req,
    output const_data_t      emit_data,
    output const_dest_t      emit_dest
);

    sb_data_t    high_word;
    sb_data_t    low_word;
    const_dest_t dest;
    logic        config_done;
    sb_addr_t    read_offset;

    // Register updates and emit request
    always_ff @(posedge clock) begin
        if (!reset) begin
            high_word   <= '0;
            low_word    <= '0;
            dest        <= '0;
            config_done <= 1'b0;
            emit_req    <= 1'b0;
        end else begin
            config_done <= 1'b0;
            emit_req    <= 1'b0;
            if (cmd_strobe) begin
                case (cmd)
                    cmd_emit: begin
                        low_word <= cmd_data;
                        emit_req <= 1'b1;
                    end
                    cmd_set_high: begin
                        high_word   <= cmd_data;
                        config_done <= 1'b1;
                    end
                    cmd_set_dest: begin
                        dest        <= cmd_data[`CONST_DEST_WIDTH-1:0];
                        config_done <= 1'b1;
                    end
                    default: begin
                        // Unknown offset, nothing to apply
                        config_done <= 1'b1;
                    end
                endcase
            end
        end
    end

    // Emit completion comes from the stream side
    assign cmd_done = config_done || emit_done;

    // Low word is already updated when emit_req is seen
    assign emit_data = {high_word, low_word};
    assign emit_dest = dest;

    // Readback
    assign read_offset = sb_address - `CONST_BASE_ADDRESS;

    always_comb begin
        case (read_offset)
            `CONST_OFS_LOW:  sb_read_data = low_word;
            `CONST_OFS_HIGH: sb_read_data = high_word;
            `CONST_OFS_DEST: sb_read_data = sb_data_t'(dest);
            default:         sb_read_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== constant_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module constant_source import bus_pkg::*, stream_pkg::*; (
    input  wire              clock,
    input  wire              reset,
    input  wire sb_addr_t    sb_address,
    input  wire sb_data_t    sb_write_data,
    input  wire              sb_write_strobe,
    output logic             sb_ready,
    output sb_data_t         sb_read_data,
    input  wire              sync,
    output const_data_t      out_data,
    output const_dest_t      out_dest,
    output logic             out_valid,
    input  wire              out_ready
);

    // Decode to bank
    sb_cmd_e     cmd;
    sb_data_t    cmd_data;
    logic        cmd_strobe;
    logic        cmd_done;

    // Bank to emitter
    logic        emit_req;
    const_data_t emit_data;
    const_dest_t emit_dest;
    logic        emit_done;

    sb_write_decode u_decode (
        .clock          (clock),
        .reset          (reset),
        .sb_address     (sb_address),
        .sb_write_data  (sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .cmd_done       (cmd_done),
        .sb_ready       (sb_ready),
        .cmd            (cmd),
        .cmd_data       (cmd_data),
        .cmd_strobe     (cmd_strobe)
    );

    constant_register_bank u_bank (
        .clock       (clock),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_data    (cmd_data),
        .cmd_strobe  (cmd_strobe),
        .emit_done   (emit_done),
        .sb_address  (sb_address),
        .cmd_done    (cmd_done),
        .sb_read_data(sb_read_data),
        .emit_req    (emit_req),
        .emit_data   (emit_data),
        .emit_dest   (emit_dest)
    );

    stream_emitter u_emitter (
        .clock    (clock),
        .reset    (reset),
        .emit_req (emit_req),
        .emit_data(emit_data),
        .emit_dest(emit_dest),
        .sync     (sync),
        .out_ready(out_ready),
        .out_data (out_data),
        .out_dest (out_dest),
        .out_valid(out_valid),
        .emit_done(emit_done)
    );

endmodule

`default_nettype wire

// ==== sb_write_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "const_cfg.svh"

module sb_write_decode import bus_pkg::*; (
    input  wire           clock,
    input  wire           reset,
    input  wire sb_addr_t sb_address,
    input  wire sb_data_t sb_write_data,
    input  wire           sb_write_strobe,
    input  wire           cmd_done,
    output logic          sb_ready,
    output sb_cmd_e       cmd,
    output sb_data_t      cmd_data,
    output logic          cmd_strobe
);

    typedef enum logic {
        st_idle = 1'b0,
        st_busy = 1'b1
    } state_t;

    state_t   state;
    logic     accept;
    sb_addr_t offset_q;
    sb_data_t data_q;

    // Bus only takes a write while nothing is in flight
    assign sb_ready = (state == st_idle);
    assign accept   = sb_write_strobe && sb_ready;

    // Offset and data of the accepted write
    always_ff @(posedge clock) begin
        if (accept) begin
            offset_q <= sb_address - `CONST_BASE_ADDRESS;
            data_q   <= sb_write_data;
        end
    end

    // Idle/busy control, cmd_strobe one cycle after acceptance
    always_ff @(posedge clock) begin
        if (!reset) begin
            state      <= st_idle;
            cmd_strobe <= 1'b0;
        end else begin
            cmd_strobe <= 1'b0;
            case (state)
                st_idle: begin
                    if (accept) begin
                        state      <= st_busy;
                        cmd_strobe <= 1'b1;
                    end
                end
                st_busy: begin
                    // Held here until the bank reports completion
                    if (cmd_done) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Offset to command map
    always_comb begin
        case (offset_q)
            `CONST_OFS_LOW:  cmd = cmd_emit;
            `CONST_OFS_HIGH: cmd = cmd_set_high;
            `CONST_OFS_DEST: cmd = cmd_set_dest;
            default:         cmd = cmd_none;
        endcase
    end

    assign cmd_data = data_q;

endmodule

`default_nettype wire

// ==== stream_emitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_emitter import stream_pkg::*; (
    input  wire              clock,
    input  wire              reset,
    input  wire              emit_req,
    input  wire const_data_t emit_data,
    input  wire const_dest_t emit_dest,
    input  wire              sync,
    input  wire              out_ready,
    output const_data_t      out_data,
    output const_dest_t      out_dest,
    output logic             out_valid,
    output logic             emit_done
);

    typedef enum logic [1:0] {
        st_idle      = 2'd0,
        st_wait_sync = 2'd1,
        st_present   = 2'd2
    } state_t;

    state_t state;

    // Payload taken at request time, held through the handshake
    always_ff @(posedge clock) begin
        if (state == st_idle && emit_req) begin
            out_data <= emit_data;
            out_dest <= emit_dest;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (emit_req) begin
                        state <= st_wait_sync;
                    end
                end
                st_wait_sync: begin
                    if (sync) begin
                        state <= st_present;
                    end
                end
                st_present: begin
                    if (out_ready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    assign out_valid = (state == st_present);

    // High only in the handshake cycle
    assign emit_done = out_valid && out_ready;

endmodule

`default_nettype wire

// ==== stream_pkg.sv ====
`default_nettype none

`include "const_cfg.svh"

package stream_pkg;

    // Full constant as presented on the stream
    typedef logic [`CONST_DATA_WIDTH-1:0] const_data_t;

    // Routing tag sent along with the constant
    typedef logic [`CONST_DEST_WIDTH-1:0] const_dest_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+.
bus_pkg.sv
stream_pkg.sv
sb_write_decode.sv
constant_register_bank.sv
stream_emitter.sv
constant_source.sv
tb_constant_source.sv

// ==== tb_constant_source.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "const_cfg.svh"

module tb_constant_source import bus_pkg::*, stream_pkg::*; ();

    localparam int config_rounds = 6;
    localparam int emit_rounds   = 10;
    // Bus writes issued below including the busy and invalid phase
    localparam int num_transactions = 2 * config_rounds + 3 * emit_rounds + 5;
    localparam int timeout_cycles   = 40 * num_transactions + 200;
    // Longest run of out_ready low before it is forced high
    localparam int max_stall = 8;

    logic        clock;
    logic        reset;
    sb_addr_t    sb_address;
    sb_data_t    sb_write_data;
    logic        sb_write_strobe;
    logic        sb_ready;
    sb_data_t    sb_read_data;
    logic        sync;
    const_data_t out_data;
    const_dest_t out_dest;
    logic        out_valid;
    logic        out_ready;

    // Reference copies of the bank registers with dest kept as written
    sb_data_t model_high;
    sb_data_t model_dest;
    sb_data_t model_low;

    logic [15:0] lfsr_state;
    int          cycle_count;
    int          emit_count;
    int          transfer_count;
    logic        held_valid;
    const_data_t held_data;
    const_dest_t held_dest;
    logic [`CONST_DEST_WIDTH+`CONST_DATA_WIDTH-1:0] beat_expected;

    constant_source u_constant_source (
        .clock          (clock),
        .reset          (reset),
        .sb_address     (sb_address),
        .sb_write_data  (sb_write_data),
        .sb_write_strobe(sb_write_strobe),
        .sb_ready       (sb_ready),
        .sb_read_data   (sb_read_data),
        .sync           (sync),
        .out_data       (out_data),
        .out_dest       (out_dest),
        .out_valid      (out_valid),
        .out_ready      (out_ready)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #10 clock = ~clock;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Tag as read back and zero-extended to a bus word
    function automatic sb_data_t expected_tag(input sb_data_t written);
        sb_data_t tag;
        tag = '0;
        tag[`CONST_DEST_WIDTH-1:0] = written[`CONST_DEST_WIDTH-1:0];
        return tag;
    endfunction

    // Stream beat for the given registers with the tag above the constant
    function automatic logic [`CONST_DEST_WIDTH+`CONST_DATA_WIDTH-1:0] expected_word(
        input sb_data_t high,
        input sb_data_t dest,
        input sb_data_t low
    );
        logic [`CONST_DEST_WIDTH-1:0] tag;
        tag = dest[`CONST_DEST_WIDTH-1:0];
        return {tag, high, low};
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h at %0t",
                     name, got, expected, $time);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic check_readback(input sb_addr_t offset, input sb_data_t expected);
        sb_address = `CONST_BASE_ADDRESS + offset;
        #1;
        check_value($sformatf("sb_read_data[0x%0h]", offset), sb_read_data, expected);
    endtask

    task automatic check_all_readback();
        check_readback(`CONST_OFS_LOW, model_low);
        check_readback(`CONST_OFS_HIGH, model_high);
        check_readback(`CONST_OFS_DEST, expected_tag(model_dest));
    endtask

    // Strobe while the bus is busy that the DUT must drop
    task automatic drive_ignored_write();
        sb_address      = `CONST_BASE_ADDRESS + (random_bits(2) << 2);
        sb_write_data   = random_bits(32);
        sb_write_strobe = 1'b1;
    endtask

    // Leaves the caller in the first cycle after the accepting edge
    task automatic bus_write(input sb_addr_t address, input sb_data_t data);
        check_value("sb_ready", sb_ready, 1'b1);
        sb_address      = address;
        sb_write_data   = data;
        sb_write_strobe = 1'b1;
        next_cycle();
        sb_write_strobe = 1'b0;
        check_value("sb_ready", sb_ready, 1'b0);
    endtask

    task automatic config_write(input sb_addr_t offset, input sb_data_t data,
                                input logic busy_strobes);
        sb_data_t expected;
        bus_write(`CONST_BASE_ADDRESS + offset, data);
        if (offset == `CONST_OFS_HIGH) begin
            model_high = data;
            expected   = model_high;
        end else begin
            model_dest = data;
            expected   = expected_tag(model_dest);
        end
        if (busy_strobes) begin
            sb_write_data   = ~data;
            sb_write_strobe = 1'b1;
        end
        next_cycle();
        check_value("sb_ready", sb_ready, 1'b0);
        // New value visible in the second busy cycle
        check_readback(offset, expected);
        next_cycle();
        sb_write_strobe = 1'b0;
        check_value("sb_ready", sb_ready, 1'b1);
        check_readback(offset, expected);
    endtask

    task automatic emit(input sb_data_t low, input logic busy_strobes);
        int   gap;
        int   stall;
        logic handshake;
        logic finished;
        model_low = low;
        emit_count++;
        bus_write(`CONST_BASE_ADDRESS + `CONST_OFS_LOW, low);
        // Two cycles until the emitter waits for sync
        gap = 2 + int'(random_bits(3));
        for (int i = 0; i < gap; i++) begin
            out_ready = random_bits(1) != 0;
            if (busy_strobes) begin
                drive_ignored_write();
            end
            next_cycle();
            check_value("out_valid", out_valid, 1'b0);
            check_value("sb_ready", sb_ready, 1'b0);
        end
        sb_write_strobe = 1'b0;
        sync = 1'b1;
        next_cycle();
        sync = 1'b0;
        check_value("out_valid", out_valid, 1'b1);
        stall    = 0;
        finished = 1'b0;
        while (!finished) begin
            if (stall >= max_stall) begin
                out_ready = 1'b1;
            end else begin
                out_ready = random_bits(1) != 0;
            end
            if (busy_strobes) begin
                drive_ignored_write();
            end
            check_value("sb_ready", sb_ready, 1'b0);
            handshake = out_valid && out_ready;
            next_cycle();
            if (handshake) begin
                finished = 1'b1;
            end else begin
                stall++;
            end
        end
        sb_write_strobe = 1'b0;
        out_ready       = 1'b0;
        // Bus free again the cycle after the handshake
        check_value("out_valid", out_valid, 1'b0);
        check_value("sb_ready", sb_ready, 1'b1);
        check_value("transfer count", transfer_count, emit_count);
    endtask

    task automatic invalid_write(input sb_addr_t address, input sb_data_t data);
        int transfers_before;
        transfers_before = transfer_count;
        bus_write(address, data);
        next_cycle();
        check_value("sb_ready", sb_ready, 1'b0);
        next_cycle();
        check_value("sb_ready", sb_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        check_all_readback();
        check_value("transfer count", transfer_count, transfers_before);
    endtask

    // Sync alone must not start a transfer without a pending request
    task automatic idle_sync_pulse();
        out_ready = 1'b1;
        sync      = 1'b1;
        next_cycle();
        sync = 1'b0;
        repeat (3) begin
            next_cycle();
            check_value("out_valid", out_valid, 1'b0);
        end
        out_ready = 1'b0;
    endtask

    // Stream monitor sampled mid-cycle
    always @(negedge clock) begin
        if (reset && out_valid) begin
            if (held_valid) begin
                check_value("out_data stable", out_data, held_data);
                check_value("out_dest stable", out_dest, held_dest);
            end
            if (out_ready) begin
                beat_expected = expected_word(model_high, model_dest, model_low);
                check_value("out_data", out_data, beat_expected[`CONST_DATA_WIDTH-1:0]);
                check_value("out_dest", out_dest,
                            beat_expected[`CONST_DATA_WIDTH +: `CONST_DEST_WIDTH]);
                transfer_count++;
                held_valid = 1'b0;
            end else begin
                held_valid = 1'b1;
                held_data  = out_data;
                held_dest  = out_dest;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the test did not finish within %0d clock cycles",
                     timeout_cycles);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    end

    initial begin
        reset           = 1'b0;
        sb_address      = `CONST_BASE_ADDRESS;
        sb_write_data   = '0;
        sb_write_strobe = 1'b0;
        sync            = 1'b0;
        out_ready       = 1'b0;
        model_high      = '0;
        model_dest      = '0;
        model_low       = '0;
        lfsr_state      = 16'd41722;
        cycle_count     = 0;
        emit_count      = 0;
        transfer_count  = 0;
        held_valid      = 1'b0;

        repeat (2) @(posedge clock);
        #2;
        reset = 1'b1;

        // Reset values
        check_value("sb_ready", sb_ready, 1'b1);
        check_value("out_valid", out_valid, 1'b0);
        check_all_readback();

        for (int i = 0; i < config_rounds; i++) begin
            config_write(`CONST_OFS_HIGH, random_bits(32), 1'b0);
            config_write(`CONST_OFS_DEST, random_bits(32), 1'b0);
        end

        // Sync gating and back-pressure
        for (int i = 0; i < emit_rounds; i++) begin
            config_write(`CONST_OFS_HIGH, random_bits(32), 1'b0);
            config_write(`CONST_OFS_DEST, random_bits(32), 1'b0);
            emit(random_bits(32), 1'b0);
        end

        // Strobes during busy cycles and then unknown offsets
        emit(random_bits(32), 1'b1);
        check_all_readback();
        config_write(`CONST_OFS_HIGH, random_bits(32), 1'b1);
        check_all_readback();
        invalid_write(`CONST_BASE_ADDRESS + 32'h0000_000C, random_bits(32));
        invalid_write(`CONST_BASE_ADDRESS + 32'h0000_0100, random_bits(32));
        invalid_write(32'h0000_0004, random_bits(32));
        idle_sync_pulse();
        check_value("transfer count", transfer_count, emit_count);

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
